/* rtl/mem_arbiter_pkg.sv */
// widths and encodings for the shared memory bus; tag zero is reserved for reject and no return
`default_nettype none

package mem_arbiter_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int addr_width = 32;
    localparam int data_width = 64;
    // 16 tags, value 0 never names a transaction
    localparam int tag_width  = 4;
    localparam int tag_count  = 16;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [tag_width-1:0]  mem_tag_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // command levels on the memory bus
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_t;

    // side that owns an outstanding tag
    typedef enum logic [1:0] {
        owner_none  = 2'b00,
        owner_fetch = 2'b01,
        owner_data  = 2'b10
    } owner_t;

    // status seen by the outside
    typedef enum logic [1:0] {
        no_error     = 2'b00,
        halted_done  = 2'b01,
        illegal_inst = 2'b10
    } error_status_t;

endpackage

`default_nettype wire

/* rtl/bus_select.sv */
// purely combinational; memory must answer the request in the same cycle it sees it
`default_nettype none

module bus_select (
    input  wire logic                          fetch_request,
    input  wire mem_arbiter_pkg::addr_t        fetch_addr,
    input  wire mem_arbiter_pkg::bus_command_t data_command,
    input  wire mem_arbiter_pkg::addr_t        data_addr,
    input  wire mem_arbiter_pkg::data_t        data_wdata,
    input  wire logic                          fetch_enable,
    input  wire mem_arbiter_pkg::mem_tag_t     mem_response,
    output mem_arbiter_pkg::bus_command_t      mem_command,
    output mem_arbiter_pkg::addr_t             mem_addr,
    output mem_arbiter_pkg::data_t             mem_wdata,
    output logic                               fetch_stall,
    output mem_arbiter_pkg::mem_tag_t          fetch_accept_tag,
    output mem_arbiter_pkg::mem_tag_t          data_accept_tag,
    output mem_arbiter_pkg::owner_t            issue_owner
);

    ////////////////////////////////////////
    // grant and answer routing
    ////////////////////////////////////////

    always_comb begin
        // idle bus by default
        mem_command      = mem_arbiter_pkg::bus_none;
        mem_addr         = fetch_addr;
        // store data only matters with a store command
        mem_wdata        = data_wdata;
        fetch_stall      = 1'b0;
        fetch_accept_tag = '0;
        data_accept_tag  = '0;
        issue_owner      = mem_arbiter_pkg::owner_none;

        if (data_command != mem_arbiter_pkg::bus_none) begin
            // data side always wins
            mem_command     = data_command;
            mem_addr        = data_addr;
            data_accept_tag = mem_response;
            // fetch lost this cycle, keeps its request up
            fetch_stall     = fetch_request;
            // stores never get an owner, so never strobe back
            if (data_command == mem_arbiter_pkg::bus_load) begin
                issue_owner = mem_arbiter_pkg::owner_data;
            end
        end else if (fetch_request && fetch_enable) begin
            // fetch always goes out as a load
            mem_command      = mem_arbiter_pkg::bus_load;
            mem_addr         = fetch_addr;
            fetch_accept_tag = mem_response;
            issue_owner      = mem_arbiter_pkg::owner_fetch;
        end
    end

endmodule

`default_nettype wire

/* rtl/tag_owner_table.sv */
// memory may only re-answer an outstanding tag in the cycle it returns; earliest return is 1 cycle
`default_nettype none

module tag_owner_table (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire mem_arbiter_pkg::owner_t   issue_owner,
    input  wire mem_arbiter_pkg::mem_tag_t mem_response,
    input  wire mem_arbiter_pkg::mem_tag_t mem_return_tag,
    input  wire mem_arbiter_pkg::data_t    mem_return_data,
    output logic                           fetch_data_valid,
    output mem_arbiter_pkg::data_t         fetch_data,
    output logic                           data_return_valid,
    output mem_arbiter_pkg::data_t         data_return,
    output logic                           outstanding_empty
);

    // one owner per tag value, entry 0 stays unused
    mem_arbiter_pkg::owner_t owner_table [mem_arbiter_pkg::tag_count];
    mem_arbiter_pkg::owner_t return_owner;
    // wide enough for every tag at once
    logic [mem_arbiter_pkg::tag_width:0] outstanding_count;
    logic issue_write;
    logic return_hit;

    ////////////////////////////////////////
    // return lookup
    ////////////////////////////////////////

    // tag zero means nothing returns this cycle
    always_comb begin
        return_owner = mem_arbiter_pkg::owner_none;
        if (mem_return_tag != '0) begin
            return_owner = owner_table[mem_return_tag];
        end
    end

    assign return_hit  = (return_owner != mem_arbiter_pkg::owner_none);
    // accepted load only, rejects and stores leave no trace
    assign issue_write = (mem_response != '0) &&
                         (issue_owner != mem_arbiter_pkg::owner_none);

    // strobe only the side that owns the tag
    assign fetch_data_valid  = (return_owner == mem_arbiter_pkg::owner_fetch);
    assign data_return_valid = (return_owner == mem_arbiter_pkg::owner_data);
    assign fetch_data        = mem_return_data;
    assign data_return       = mem_return_data;

    ////////////////////////////////////////
    // owner table and count
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_arbiter_pkg::tag_count; i++) begin
                owner_table[i] <= mem_arbiter_pkg::owner_none;
            end
        end else begin
            // free first
            if (return_hit) begin
                owner_table[mem_return_tag] <= mem_arbiter_pkg::owner_none;
            end
            // so a tag re-answered on its return cycle stays owned
            if (issue_write) begin
                owner_table[mem_response] <= issue_owner;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            outstanding_count <= '0;
        end else begin
            case ({issue_write, return_hit})
                2'b10: outstanding_count <= outstanding_count + 1'b1;
                2'b01: outstanding_count <= outstanding_count - 1'b1;
                // both or neither, net zero
                default: outstanding_count <= outstanding_count;
            endcase
        end
    end

    assign outstanding_empty = (outstanding_count == '0);

endmodule

`default_nettype wire

/* rtl/halt_control.sv */
// halt and illegal are sticky until reset; halt only blocks fetch, data requests keep flowing
`default_nettype none

module halt_control (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      halt,
    input  wire logic                      illegal,
    input  wire logic                      outstanding_empty,
    output logic                           fetch_enable,
    output logic                           halt_done,
    output mem_arbiter_pkg::error_status_t error_status
);

    logic halted;
    logic illegal_seen;

    ////////////////////////////////////////
    // sticky flags
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halted       <= 1'b0;
            illegal_seen <= 1'b0;
        end else begin
            // pulses latch, nothing clears them
            if (halt) begin
                halted <= 1'b1;
            end
            if (illegal) begin
                illegal_seen <= 1'b1;
            end
        end
    end

    // fetch blocked from the cycle after the halt pulse
    assign fetch_enable = !halted;
    // done once every accepted load is back
    assign halt_done    = halted && outstanding_empty;

    // illegal wins over a finished halt
    always_comb begin
        error_status = mem_arbiter_pkg::no_error;
        if (illegal_seen) begin
            error_status = mem_arbiter_pkg::illegal_inst;
        end else if (halt_done) begin
            error_status = mem_arbiter_pkg::halted_done;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
// fetch and data share one memory bus; data wins, accept tags answer in the same cycle
`default_nettype none

module mem_arbiter (
    input  wire logic                          clock,
    input  wire logic                          reset,
    // fetch side
    input  wire logic                          fetch_request,
    input  wire mem_arbiter_pkg::addr_t        fetch_addr,
    output mem_arbiter_pkg::mem_tag_t          fetch_accept_tag,
    output logic                               fetch_stall,
    output logic                               fetch_data_valid,
    output mem_arbiter_pkg::data_t             fetch_data,
    // data side
    input  wire mem_arbiter_pkg::bus_command_t data_command,
    input  wire mem_arbiter_pkg::addr_t        data_addr,
    input  wire mem_arbiter_pkg::data_t        data_wdata,
    output mem_arbiter_pkg::mem_tag_t          data_accept_tag,
    output logic                               data_return_valid,
    output mem_arbiter_pkg::data_t             data_return,
    // memory side
    output mem_arbiter_pkg::bus_command_t      mem_command,
    output mem_arbiter_pkg::addr_t             mem_addr,
    output mem_arbiter_pkg::data_t             mem_wdata,
    input  wire mem_arbiter_pkg::mem_tag_t     mem_response,
    input  wire mem_arbiter_pkg::mem_tag_t     mem_return_tag,
    input  wire mem_arbiter_pkg::data_t        mem_return_data,
    // control
    input  wire logic                          halt,
    input  wire logic                          illegal,
    output logic                               halt_done,
    output mem_arbiter_pkg::error_status_t     error_status
);

    mem_arbiter_pkg::owner_t issue_owner;
    logic fetch_enable;
    logic outstanding_empty;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    bus_select bus_select_0 (
        .fetch_request    (fetch_request),
        .fetch_addr       (fetch_addr),
        .data_command     (data_command),
        .data_addr        (data_addr),
        .data_wdata       (data_wdata),
        .fetch_enable     (fetch_enable),
        .mem_response     (mem_response),
        .mem_command      (mem_command),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .fetch_stall      (fetch_stall),
        .fetch_accept_tag (fetch_accept_tag),
        .data_accept_tag  (data_accept_tag),
        .issue_owner      (issue_owner)
    );

    // records owners of accepted loads, steers returns
    tag_owner_table tag_owner_table_0 (
        .clock             (clock),
        .reset             (reset),
        .issue_owner       (issue_owner),
        .mem_response      (mem_response),
        .mem_return_tag    (mem_return_tag),
        .mem_return_data   (mem_return_data),
        .fetch_data_valid  (fetch_data_valid),
        .fetch_data        (fetch_data),
        .data_return_valid (data_return_valid),
        .data_return       (data_return),
        .outstanding_empty (outstanding_empty)
    );

    halt_control halt_control_0 (
        .clock             (clock),
        .reset             (reset),
        .halt              (halt),
        .illegal           (illegal),
        .outstanding_empty (outstanding_empty),
        .fetch_enable      (fetch_enable),
        .halt_done         (halt_done),
        .error_status      (error_status)
    );

endmodule

`default_nettype wire

/* testbench/mem_arbiter_assert.sv */
// bound into mem_arbiter so the clock and the internal outstanding flag are visible; idle in reset
`default_nettype none

module mem_arbiter_assert (
    input wire logic                          clock,
    input wire logic                          reset,
    input wire mem_arbiter_pkg::bus_command_t data_command,
    input wire mem_arbiter_pkg::bus_command_t mem_command,
    input wire mem_arbiter_pkg::mem_tag_t     mem_response,
    input wire logic                          outstanding_empty,
    input wire logic                          fetch_data_valid,
    input wire logic                          data_return_valid
);

    // assertion failures so far
    int failure_count = 0;

    ////////////////////////////////////////
    // bus rules
    ////////////////////////////////////////

    // data side always wins the bus
    data_reaches_bus: assert property (@(posedge clock) disable iff (reset)
        (data_command != mem_arbiter_pkg::bus_none) |-> (mem_command == data_command))
    else begin
        failure_count++;
        $error("data command did not reach the memory bus");
    end

    // an accepted store leaves the owner table empty, so nothing can strobe back
    store_adds_no_entry: assert property (@(posedge clock) disable iff (reset)
        (outstanding_empty && (mem_command == mem_arbiter_pkg::bus_store) &&
         (mem_response != '0)) |=> outstanding_empty)
    else begin
        failure_count++;
        $error("accepted store left an owner entry behind");
    end

    ////////////////////////////////////////
    // return rules
    ////////////////////////////////////////

    one_return_side: assert property (@(posedge clock) disable iff (reset)
        !(fetch_data_valid && data_return_valid))
    else begin
        failure_count++;
        $error("fetch and data return strobes high together");
    end

endmodule

bind mem_arbiter mem_arbiter_assert bus_rules (
    .clock             (clock),
    .reset             (reset),
    .data_command      (data_command),
    .mem_command       (mem_command),
    .mem_response      (mem_response),
    .outstanding_empty (outstanding_empty),
    .fetch_data_valid  (fetch_data_valid),
    .data_return_valid (data_return_valid)
);

`default_nettype wire

/* testbench/mem_arbiter_tb.sv */
// drives on the rising edge, checks on the falling edge; memory returns only outstanding load tags
`default_nettype none

module mem_arbiter_tb;

    localparam int period         = 100;
    localparam int reset_cycles   = 5;
    localparam int random_cycles  = 400;
    localparam int halt_cycles    = 60;
    localparam int drain_limit    = 40;
    localparam int illegal_cycles = 10;
    localparam int total_cycles   = reset_cycles + random_cycles + halt_cycles +
                                    drain_limit + illegal_cycles;
    // two periods per planned cycle
    localparam int watchdog_time  = total_cycles * 200;
    localparam int unsigned random_seed = 32'h47c21edd;

    logic clock;
    logic reset;
    logic fetch_request;
    mem_arbiter_pkg::addr_t fetch_addr;
    mem_arbiter_pkg::bus_command_t data_command;
    mem_arbiter_pkg::addr_t data_addr;
    mem_arbiter_pkg::data_t data_wdata;
    mem_arbiter_pkg::mem_tag_t mem_response;
    mem_arbiter_pkg::mem_tag_t mem_return_tag;
    mem_arbiter_pkg::data_t mem_return_data;
    logic halt;
    logic illegal;
    mem_arbiter_pkg::mem_tag_t fetch_accept_tag;
    logic fetch_stall;
    logic fetch_data_valid;
    mem_arbiter_pkg::data_t fetch_data;
    mem_arbiter_pkg::mem_tag_t data_accept_tag;
    logic data_return_valid;
    mem_arbiter_pkg::data_t data_return;
    mem_arbiter_pkg::bus_command_t mem_command;
    mem_arbiter_pkg::addr_t mem_addr;
    mem_arbiter_pkg::data_t mem_wdata;
    logic halt_done;
    mem_arbiter_pkg::error_status_t error_status;

    // checker view of who owns each tag and at which address
    mem_arbiter_pkg::owner_t tag_owner [mem_arbiter_pkg::tag_count];
    mem_arbiter_pkg::addr_t tag_addr [mem_arbiter_pkg::tag_count];
    // memory view of outstanding loads
    bit mem_busy [mem_arbiter_pkg::tag_count];
    mem_arbiter_pkg::addr_t mem_load_addr [mem_arbiter_pkg::tag_count];
    int mem_delay [mem_arbiter_pkg::tag_count];

    bit model_halted;
    bit model_illegal;
    bit fetch_active;
    bit data_active;
    bit fetch_pending;
    bit data_pending;
    bit halt_request;
    bit illegal_request;
    bit done_seen;
    int max_outstanding;
    int check_count;
    int error_count;
    int test_start_errors;
    int total_errors;

    mem_arbiter dut (.*);

    always #(period / 2) clock = ~clock;

    // reference data for any load address
    function automatic mem_arbiter_pkg::data_t expected_data(input mem_arbiter_pkg::addr_t addr);
        return {addr, ~addr};
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////
    // stimulus and memory, rising edge
    ////////////////////////////////////////

    task automatic drive_cycle();
        int ready [$];
        int chosen;
        int start;
        int t;
        // requesters hold a rejected request
        if (!fetch_active) begin
            fetch_request <= 1'b0;
        end else if (!fetch_pending) begin
            fetch_request <= ($urandom % 3 != 0);
            fetch_addr    <= $urandom & 32'hffff_fffc;
        end
        if (!data_active) begin
            data_command <= mem_arbiter_pkg::bus_none;
        end else if (!data_pending) begin
            case ($urandom % 4)
                2: data_command <= mem_arbiter_pkg::bus_load;
                3: data_command <= mem_arbiter_pkg::bus_store;
                default: data_command <= mem_arbiter_pkg::bus_none;
            endcase
            data_addr  <= $urandom & 32'hffff_fff8;
            data_wdata <= {$urandom, $urandom};
        end
        halt            <= halt_request;
        illegal         <= illegal_request;
        halt_request    = 1'b0;
        illegal_request = 1'b0;
        // memory returns at most one tag per cycle
        for (int i = 1; i < mem_arbiter_pkg::tag_count; i++) begin
            if (mem_busy[i]) begin
                mem_delay[i]--;
                if (mem_delay[i] <= 0) begin
                    ready.push_back(i);
                end
            end
        end
        if (ready.size() > 0) begin
            t = ready[$urandom % ready.size()];
            mem_return_tag  <= mem_arbiter_pkg::mem_tag_t'(t);
            mem_return_data <= expected_data(mem_load_addr[t]);
        end else begin
            mem_return_tag  <= '0;
            mem_return_data <= {$urandom, $urandom};
        end
        // free tag ready for whatever the bus carries
        chosen = 0;
        start  = 1 + int'($urandom % 15);
        for (int n = 0; n < 15; n++) begin
            t = 1 + (start - 1 + n) % 15;
            if (!mem_busy[t] && chosen == 0) begin
                chosen = t;
            end
        end
        // about a quarter rejected
        if ($urandom % 4 == 0) begin
            chosen = 0;
        end
        mem_response <= mem_arbiter_pkg::mem_tag_t'(chosen);
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            drive_cycle();
        end
    end

    ////////////////////////////////////////
    // checks, falling edge
    ////////////////////////////////////////

    task automatic check_cycle();
        mem_arbiter_pkg::bus_command_t exp_command;
        mem_arbiter_pkg::addr_t exp_addr;
        mem_arbiter_pkg::mem_tag_t exp_fetch_tag;
        mem_arbiter_pkg::mem_tag_t exp_data_tag;
        mem_arbiter_pkg::owner_t issuer;
        mem_arbiter_pkg::owner_t returner;
        mem_arbiter_pkg::error_status_t exp_status;
        logic exp_stall;
        logic exp_done;
        int outstanding;
        exp_command   = mem_arbiter_pkg::bus_none;
        exp_addr      = '0;
        exp_fetch_tag = '0;
        exp_data_tag  = '0;
        exp_stall     = 1'b0;
        issuer        = mem_arbiter_pkg::owner_none;
        // data wins and fetch goes out only while data idle and not halted
        if (data_command != mem_arbiter_pkg::bus_none) begin
            exp_command  = data_command;
            exp_addr     = data_addr;
            exp_data_tag = mem_response;
            exp_stall    = fetch_request;
            if (data_command == mem_arbiter_pkg::bus_load) begin
                issuer = mem_arbiter_pkg::owner_data;
            end
        end else if (fetch_request && !model_halted) begin
            exp_command   = mem_arbiter_pkg::bus_load;
            exp_addr      = fetch_addr;
            exp_fetch_tag = mem_response;
            issuer        = mem_arbiter_pkg::owner_fetch;
        end
        compare("mem_command", 64'(exp_command), 64'(mem_command));
        if (exp_command != mem_arbiter_pkg::bus_none) begin
            compare("mem_addr", 64'(exp_addr), 64'(mem_addr));
        end
        if (exp_command == mem_arbiter_pkg::bus_store) begin
            compare("mem_wdata", data_wdata, mem_wdata);
        end
        compare("fetch_stall", 64'(exp_stall), 64'(fetch_stall));
        compare("fetch_accept_tag", 64'(exp_fetch_tag), 64'(fetch_accept_tag));
        compare("data_accept_tag", 64'(exp_data_tag), 64'(data_accept_tag));
        // returns go to the recorded owner only
        returner = mem_arbiter_pkg::owner_none;
        if (mem_return_tag != '0) begin
            returner = tag_owner[mem_return_tag];
        end
        compare("fetch_data_valid", 64'(returner == mem_arbiter_pkg::owner_fetch),
                64'(fetch_data_valid));
        compare("data_return_valid", 64'(returner == mem_arbiter_pkg::owner_data),
                64'(data_return_valid));
        if (returner == mem_arbiter_pkg::owner_fetch) begin
            compare("fetch_data", expected_data(tag_addr[mem_return_tag]), fetch_data);
        end
        if (returner == mem_arbiter_pkg::owner_data) begin
            compare("data_return", expected_data(tag_addr[mem_return_tag]), data_return);
        end
        // halt done needs every accepted load back
        outstanding = 0;
        for (int i = 1; i < mem_arbiter_pkg::tag_count; i++) begin
            if (tag_owner[i] != mem_arbiter_pkg::owner_none) begin
                outstanding++;
            end
        end
        if (outstanding > max_outstanding) begin
            max_outstanding = outstanding;
        end
        exp_done   = model_halted && (outstanding == 0);
        exp_status = model_illegal ? mem_arbiter_pkg::illegal_inst :
                     exp_done ? mem_arbiter_pkg::halted_done : mem_arbiter_pkg::no_error;
        compare("halt_done", 64'(exp_done), 64'(halt_done));
        compare("error_status", 64'(exp_status), 64'(error_status));
        if (halt_done) begin
            done_seen = 1'b1;
        end
        // free before record since a tag may be re-answered on its return
        if (returner != mem_arbiter_pkg::owner_none) begin
            tag_owner[mem_return_tag] = mem_arbiter_pkg::owner_none;
        end
        if (issuer != mem_arbiter_pkg::owner_none && mem_response != '0) begin
            tag_owner[mem_response] = issuer;
            tag_addr[mem_response]  = exp_addr;
        end
        fetch_pending = fetch_request && (exp_fetch_tag == '0);
        data_pending  = (data_command != mem_arbiter_pkg::bus_none) && (mem_response == '0);
        if (halt) begin
            model_halted = 1'b1;
        end
        if (illegal) begin
            model_illegal = 1'b1;
        end
    endtask

    // memory bookkeeping from what it sees on the bus
    task automatic record_memory();
        if (mem_return_tag != '0) begin
            mem_busy[mem_return_tag] = 1'b0;
        end
        if (mem_command == mem_arbiter_pkg::bus_load && mem_response != '0) begin
            mem_busy[mem_response]      = 1'b1;
            mem_load_addr[mem_response] = mem_addr;
            mem_delay[mem_response]     = 1 + int'($urandom % 6);
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            check_cycle();
            record_memory();
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    // lands between the edges away from driver and checker
    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock);
        #(period / 4);
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s finished, %0d errors", name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        fetch_request = 1'b0;
        fetch_addr = '0;
        data_command = mem_arbiter_pkg::bus_none;
        data_addr = '0;
        data_wdata = '0;
        mem_response = '0;
        mem_return_tag = '0;
        mem_return_data = '0;
        halt = 1'b0;
        illegal = 1'b0;
        for (int i = 0; i < mem_arbiter_pkg::tag_count; i++) begin
            tag_owner[i] = mem_arbiter_pkg::owner_none;
            tag_addr[i]  = '0;
            mem_busy[i]  = 1'b0;
            mem_load_addr[i] = '0;
            mem_delay[i] = 0;
        end
        void'($urandom(random_seed));
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // both sides racing with several loads in flight
        fetch_active = 1'b1;
        data_active  = 1'b1;
        wait_cycles(random_cycles);
        if (max_outstanding < 2) begin
            report_failure("never had two loads outstanding at once");
        end
        finish_test("random traffic");

        // fetch blocked while data is still served
        halt_request = 1'b1;
        wait_cycles(halt_cycles);
        finish_test("halt with traffic");

        // only a rise after the data side goes idle counts
        data_active = 1'b0;
        done_seen   = 1'b0;
        for (int n = 0; n < drain_limit && !done_seen; n++) begin
            wait_cycles(1);
        end
        if (!done_seen) begin
            report_failure("halt_done never rose after the data side went idle");
        end
        finish_test("halt drain");

        // halt has completed, illegal still takes priority
        illegal_request = 1'b1;
        wait_cycles(illegal_cycles);
        compare("halt_done", 64'(1'b1), 64'(halt_done));
        compare("error_status", 64'(mem_arbiter_pkg::illegal_inst), 64'(error_status));
        finish_test("illegal after halt");

        total_errors = error_count + dut.bus_rules.failure_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, dut.bus_rules.failure_count);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/mem_arbiter_pkg.sv
rtl/bus_select.sv
rtl/tag_owner_table.sv
rtl/halt_control.sv
rtl/mem_arbiter.sv
testbench/mem_arbiter_assert.sv
testbench/mem_arbiter_tb.sv

/* Makefile */
# Verilator build and run for the memory arbiter testbench

TOP := mem_arbiter_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

# pass only when the pass line shows up in the output
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q -x "TEST PASS"

clean:
	rm -rf obj_dir
